// File: rtl/rs_pkg.sv
package rs_pkg;

    // field widths of one station entry
    localparam int TAG_W      = 8;   // physical register tag
    localparam int INST_NUM_W = 32;  // sequence number from rename
    localparam int IMM_W      = 32;
    localparam int ALU_OP_W   = 4;
    localparam int FUNCT3_W   = 3;

    // physical register tag, shared by rd and both sources
    typedef logic [TAG_W-1:0] tag_t;

    typedef logic [INST_NUM_W-1:0] inst_num_t;

    // sign-extended immediate as produced by decode
    typedef logic [IMM_W-1:0] imm_t;

    typedef logic [ALU_OP_W-1:0] alu_op_t;

    typedef logic [FUNCT3_W-1:0] funct3_t;

endpackage

// File: rtl/rs_entry_if.sv
`timescale 1ns/1ps

interface rs_entry_if #(
    parameter int DEPTH = 64
);
    localparam int PTR_W = $clog2(DEPTH);

    // allocation, from the entry store
    logic             alloc;        // tail slot written at this edge
    logic [PTR_W-1:0] alloc_idx;
    logic [PTR_W-1:0] head;         // oldest slot, start of the scan window
    logic [DEPTH-1:0] entry_valid;

    // per-entry operand status, from wakeup
    logic [DEPTH-1:0] src_ready;    // both sources ready

    // issue decision, from select
    logic             issue;        // slot leaves the station at this edge
    logic [PTR_W-1:0] issue_idx;

    modport store (
        output alloc,
        output alloc_idx,
        output head,
        output entry_valid,
        input  issue,
        input  issue_idx
    );

    modport wake (
        input  alloc,
        input  alloc_idx,
        input  issue,
        input  issue_idx,
        output src_ready
    );

    modport select (
        input  head,
        input  entry_valid,
        input  src_ready,
        output issue,
        output issue_idx
    );

endinterface

// File: rtl/rs_entry_store.sv
`timescale 1ns/1ps

module rs_entry_store
    import rs_pkg::*;
#(
    parameter int DEPTH = 64
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      disp_valid,
    input  inst_num_t disp_inst_num,
    input  tag_t      disp_rd,
    input  logic      disp_mem_to_reg,
    input  logic      disp_mem_read,
    input  logic      disp_mem_write,
    input  alu_op_t   disp_alu_op,
    input  logic      disp_alu_src2,
    input  funct3_t   disp_funct3,
    input  imm_t      disp_imm,
    input  tag_t      disp_src1_tag,
    input  tag_t      disp_src2_tag,
    rs_entry_if.store ent,
    output logic      disp_credit,
    output inst_num_t issue_inst_num,
    output tag_t      issue_rd,
    output logic      issue_mem_to_reg,
    output logic      issue_mem_read,
    output logic      issue_mem_write,
    output alu_op_t   issue_alu_op,
    output logic      issue_alu_src2,
    output funct3_t   issue_funct3,
    output imm_t      issue_imm,
    output tag_t      issue_src1_tag,
    output tag_t      issue_src2_tag
);
    localparam int PTR_W = $clog2(DEPTH);

    // payload array
    inst_num_t        inst_num_q [DEPTH];
    tag_t             rd_q       [DEPTH];
    alu_op_t          alu_op_q   [DEPTH];
    funct3_t          funct3_q   [DEPTH];
    imm_t             imm_q      [DEPTH];
    tag_t             src1_tag_q [DEPTH];
    tag_t             src2_tag_q [DEPTH];
    logic [DEPTH-1:0] mem_to_reg_q;
    logic [DEPTH-1:0] mem_read_q;
    logic [DEPTH-1:0] mem_write_q;
    logic [DEPTH-1:0] alu_src2_q;

    logic [DEPTH-1:0] valid_q;
    logic [PTR_W:0]   head_q;  // extra msb tells full from empty
    logic [PTR_W:0]   tail_q;
    logic [PTR_W:0]   occupancy;
    logic [PTR_W-1:0] head_idx;
    logic [PTR_W-1:0] tail_idx;
    logic             head_adv;

    assign head_idx  = head_q[PTR_W-1:0];
    assign tail_idx  = tail_q[PTR_W-1:0];
    assign occupancy = tail_q - head_q;

    // head slot already issued, step over it and hand the slot back
    assign head_adv    = (head_q != tail_q) && !valid_q[head_idx];
    assign disp_credit = head_adv && !flush;

    assign ent.alloc       = disp_valid && !flush;
    assign ent.alloc_idx   = tail_idx;
    assign ent.head        = head_idx;
    assign ent.entry_valid = valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else if (flush) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (ent.alloc) begin
                valid_q[tail_idx] <= 1'b1;
                tail_q            <= tail_q + 1'b1;
            end
            if (ent.issue)
                valid_q[ent.issue_idx] <= 1'b0;  // never the tail slot, that one is free
            if (head_adv)
                head_q <= head_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ent.alloc) begin
            inst_num_q[tail_idx]   <= disp_inst_num;
            rd_q[tail_idx]         <= disp_rd;
            mem_to_reg_q[tail_idx] <= disp_mem_to_reg;
            mem_read_q[tail_idx]   <= disp_mem_read;
            mem_write_q[tail_idx]  <= disp_mem_write;
            alu_op_q[tail_idx]     <= disp_alu_op;
            alu_src2_q[tail_idx]   <= disp_alu_src2;
            funct3_q[tail_idx]     <= disp_funct3;
            imm_q[tail_idx]        <= disp_imm;
            src1_tag_q[tail_idx]   <= disp_src1_tag;
            src2_tag_q[tail_idx]   <= disp_src2_tag;
        end
    end

    // issue payload, loaded at the same edge that raises issue_valid
    always_ff @(posedge clk) begin
        if (ent.issue) begin
            issue_inst_num   <= inst_num_q[ent.issue_idx];
            issue_rd         <= rd_q[ent.issue_idx];
            issue_mem_to_reg <= mem_to_reg_q[ent.issue_idx];
            issue_mem_read   <= mem_read_q[ent.issue_idx];
            issue_mem_write  <= mem_write_q[ent.issue_idx];
            issue_alu_op     <= alu_op_q[ent.issue_idx];
            issue_alu_src2   <= alu_src2_q[ent.issue_idx];
            issue_funct3     <= funct3_q[ent.issue_idx];
            issue_imm        <= imm_q[ent.issue_idx];
            issue_src1_tag   <= src1_tag_q[ent.issue_idx];
            issue_src2_tag   <= src2_tag_q[ent.issue_idx];
        end
    end

    // the dispatcher must hold a credit, so a full station never sees disp_valid
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (disp_valid && !flush) |-> (occupancy != (PTR_W+1)'(DEPTH)));

endmodule

// File: rtl/rs_wakeup.sv
`timescale 1ns/1ps

module rs_wakeup
    import rs_pkg::*;
#(
    parameter int DEPTH  = 64,
    parameter int N_WAKE = 3
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  tag_t              disp_src1_tag,
    input  tag_t              disp_src2_tag,
    input  logic              disp_src1_ready,
    input  logic              disp_src2_ready,
    input  logic [N_WAKE-1:0] wake_valid,
    input  tag_t [N_WAKE-1:0] wake_tag,
    rs_entry_if.wake          ent
);
    tag_t             src1_tag_q [DEPTH];
    tag_t             src2_tag_q [DEPTH];
    logic [DEPTH-1:0] rdy1_q;
    logic [DEPTH-1:0] rdy2_q;

    logic [DEPTH-1:0] hit1;
    logic [DEPTH-1:0] hit2;
    logic             disp_hit1;  // bypass for a result broadcast during dispatch
    logic             disp_hit2;

    // compare every stored tag against every active broadcast
    always_comb begin
        hit1      = '0;
        hit2      = '0;
        disp_hit1 = 1'b0;
        disp_hit2 = 1'b0;
        for (int w = 0; w < N_WAKE; w++) begin
            if (wake_valid[w]) begin
                for (int e = 0; e < DEPTH; e++) begin
                    if (src1_tag_q[e] == wake_tag[w])
                        hit1[e] = 1'b1;
                    if (src2_tag_q[e] == wake_tag[w])
                        hit2[e] = 1'b1;
                end
                if (disp_src1_tag == wake_tag[w])
                    disp_hit1 = 1'b1;
                if (disp_src2_tag == wake_tag[w])
                    disp_hit2 = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ent.alloc) begin
            src1_tag_q[ent.alloc_idx] <= disp_src1_tag;
            src2_tag_q[ent.alloc_idx] <= disp_src2_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy1_q <= '0;
            rdy2_q <= '0;
        end else if (flush) begin
            rdy1_q <= '0;
            rdy2_q <= '0;
        end else begin
            // free slots may pick up stale hits, alloc overwrites them
            rdy1_q <= rdy1_q | hit1;
            rdy2_q <= rdy2_q | hit2;
            if (ent.alloc) begin
                rdy1_q[ent.alloc_idx] <= disp_src1_ready || disp_hit1;
                rdy2_q[ent.alloc_idx] <= disp_src2_ready || disp_hit2;
            end
            if (ent.issue) begin
                rdy1_q[ent.issue_idx] <= 1'b0;
                rdy2_q[ent.issue_idx] <= 1'b0;
            end
        end
    end

    assign ent.src_ready = rdy1_q & rdy2_q;

endmodule

// File: rtl/rs_select.sv
`timescale 1ns/1ps

module rs_select #(
    parameter int DEPTH         = 64,
    parameter int WINDOW        = 32,
    parameter int ISSUE_CREDITS = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        issue_credit,
    rs_entry_if.select  ent,
    output logic        issue_valid
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(ISSUE_CREDITS + 2);  // one spare code so an overflow shows

    if (WINDOW > DEPTH || WINDOW < 1) begin : g_window_check
        $error("rs_select: WINDOW must lie in 1..DEPTH");
    end

    logic [DEPTH-1:0] cand;
    logic             found;
    logic [PTR_W-1:0] pick_idx;
    logic [PTR_W-1:0] probe;
    logic [CNT_W-1:0] credits_q;
    logic             has_credit;

    assign cand = ent.entry_valid & ent.src_ready;

    // oldest first, scanning from the head and wrapping at DEPTH
    always_comb begin
        found    = 1'b0;
        pick_idx = ent.head;
        probe    = ent.head;
        for (int k = 0; k < WINDOW; k++) begin
            probe = ent.head + PTR_W'(k);
            if (!found && cand[probe]) begin
                found    = 1'b1;
                pick_idx = probe;
            end
        end
    end

    assign has_credit = (credits_q != '0);

    // nothing leaves in a flush cycle, the entry is being discarded anyway
    assign ent.issue     = found && has_credit && !flush;
    assign ent.issue_idx = pick_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_q <= CNT_W'(ISSUE_CREDITS);
        end else begin
            // a return and an issue in the same cycle cancel
            credits_q <= credits_q + CNT_W'(issue_credit) - CNT_W'(ent.issue);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            issue_valid <= 1'b0;
        else
            issue_valid <= ent.issue;
    end

    // the ALU never hands back more than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits_q <= CNT_W'(ISSUE_CREDITS));

    // an issued slot is gone from the station one edge later
    a_issued_slot_freed: assert property (@(posedge clk) disable iff (!rst_n)
        ent.issue |=> !ent.entry_valid[$past(ent.issue_idx)]);

endmodule

// File: rtl/rs_top.sv
`timescale 1ns/1ps

module rs_top
    import rs_pkg::*;
#(
    parameter int DEPTH         = 64,
    parameter int WINDOW        = 32,
    parameter int N_WAKE        = 3,
    parameter int ISSUE_CREDITS = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,  // exception or trap return
    input  logic              disp_valid,
    input  inst_num_t         disp_inst_num,
    input  tag_t              disp_rd,
    input  logic              disp_mem_to_reg,
    input  logic              disp_mem_read,
    input  logic              disp_mem_write,
    input  alu_op_t           disp_alu_op,
    input  logic              disp_alu_src2,
    input  funct3_t           disp_funct3,
    input  imm_t              disp_imm,
    input  tag_t              disp_src1_tag,
    input  tag_t              disp_src2_tag,
    input  logic              disp_src1_ready,
    input  logic              disp_src2_ready,
    input  logic [N_WAKE-1:0] wake_valid,
    input  tag_t [N_WAKE-1:0] wake_tag,
    input  logic              issue_credit,
    output logic              disp_credit,
    output logic              issue_valid,
    output inst_num_t         issue_inst_num,
    output tag_t              issue_rd,
    output logic              issue_mem_to_reg,
    output logic              issue_mem_read,
    output logic              issue_mem_write,
    output alu_op_t           issue_alu_op,
    output logic              issue_alu_src2,
    output funct3_t           issue_funct3,
    output imm_t              issue_imm,
    output tag_t              issue_src1_tag,
    output tag_t              issue_src2_tag
);
    rs_entry_if #(.DEPTH(DEPTH)) ent ();

    rs_entry_store #(
        .DEPTH (DEPTH)
    ) u_store (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush            (flush),
        .disp_valid       (disp_valid),
        .disp_inst_num    (disp_inst_num),
        .disp_rd          (disp_rd),
        .disp_mem_to_reg  (disp_mem_to_reg),
        .disp_mem_read    (disp_mem_read),
        .disp_mem_write   (disp_mem_write),
        .disp_alu_op      (disp_alu_op),
        .disp_alu_src2    (disp_alu_src2),
        .disp_funct3      (disp_funct3),
        .disp_imm         (disp_imm),
        .disp_src1_tag    (disp_src1_tag),
        .disp_src2_tag    (disp_src2_tag),
        .ent              (ent.store),
        .disp_credit      (disp_credit),
        .issue_inst_num   (issue_inst_num),
        .issue_rd         (issue_rd),
        .issue_mem_to_reg (issue_mem_to_reg),
        .issue_mem_read   (issue_mem_read),
        .issue_mem_write  (issue_mem_write),
        .issue_alu_op     (issue_alu_op),
        .issue_alu_src2   (issue_alu_src2),
        .issue_funct3     (issue_funct3),
        .issue_imm        (issue_imm),
        .issue_src1_tag   (issue_src1_tag),
        .issue_src2_tag   (issue_src2_tag)
    );

    rs_wakeup #(
        .DEPTH  (DEPTH),
        .N_WAKE (N_WAKE)
    ) u_wakeup (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .disp_src1_tag   (disp_src1_tag),
        .disp_src2_tag   (disp_src2_tag),
        .disp_src1_ready (disp_src1_ready),
        .disp_src2_ready (disp_src2_ready),
        .wake_valid      (wake_valid),
        .wake_tag        (wake_tag),
        .ent             (ent.wake)
    );

    rs_select #(
        .DEPTH         (DEPTH),
        .WINDOW        (WINDOW),
        .ISSUE_CREDITS (ISSUE_CREDITS)
    ) u_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .issue_credit (issue_credit),
        .ent          (ent.select),
        .issue_valid  (issue_valid)
    );

endmodule

// File: include/rs_tb_tasks.svh
`ifndef RS_TB_TASKS_SVH
`define RS_TB_TASKS_SVH

// xorshift32
function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    stop_with_failure({"wrong value on ", name});
endtask

task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    if (act !== exp)
        value_error(name, 32'(exp), 32'(act));
endtask

task automatic check_inst_num(input string name, input inst_num_t exp, input inst_num_t act);
    if (act !== exp)
        value_error(name, 32'(exp), 32'(act));
endtask

task automatic check_imm(input string name, input imm_t exp, input imm_t act);
    if (act !== exp)
        value_error(name, 32'(exp), 32'(act));
endtask

// single-bit fields and funct3 are widened to the op width
task automatic check_ctrl(input string name, input alu_op_t exp, input alu_op_t act);
    if (act !== exp)
        value_error(name, 32'(exp), 32'(act));
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
        value_error(name, 32'(exp), 32'(act));
endtask

// src2 always ready, src1 optionally waits on tag1
function automatic entry_t make_entry(input logic wait1, input tag_t tag1);
    entry_t      e;
    logic [31:0] r;
    logic [31:0] t;
    r            = next_random();
    t            = next_random();
    e.inst_num   = next_random();
    e.imm        = next_random();
    e.rd         = r[TAG_W-1:0];
    e.alu_op     = r[8 +: ALU_OP_W];
    e.funct3     = r[12 +: FUNCT3_W];
    e.mem_to_reg = r[16];
    e.mem_read   = r[17];
    e.mem_write  = r[18];
    e.alu_src2   = r[19];
    e.src1_tag   = wait1 ? tag1 : t[TAG_W-1:0];
    e.src1_ready = !wait1;
    e.src2_tag   = t[8 +: TAG_W];
    e.src2_ready = 1'b1;
    return e;
endfunction

function automatic entry_t read_issue_port();
    entry_t e;
    e            = '{default: '0};
    e.inst_num   = issue_inst_num;
    e.rd         = issue_rd;
    e.mem_to_reg = issue_mem_to_reg;
    e.mem_read   = issue_mem_read;
    e.mem_write  = issue_mem_write;
    e.alu_op     = issue_alu_op;
    e.alu_src2   = issue_alu_src2;
    e.funct3     = issue_funct3;
    e.imm        = issue_imm;
    e.src1_tag   = issue_src1_tag;
    e.src2_tag   = issue_src2_tag;
    return e;
endfunction

task automatic drive_dispatch(input entry_t e);
    if (disp_credits == 0)
        stop_with_failure("dispatch attempted without a dispatch credit");
    disp         = e;
    disp_valid   = 1'b1;
    disp_credits = disp_credits - 1;
endtask

task automatic drive_wake(input int port, input tag_t tag);
    wake_valid[port] = 1'b1;
    wake_tag[port]   = tag;
endtask

// one cycle: sample outputs, run the ALU model, then clear one-cycle inputs
task automatic tick();
    @(negedge clk);
    if (issue_valid === 1'b1)
        issued_q.push_back(read_issue_port());
    if (disp_credit === 1'b1) begin
        if (no_early_credit && issued_q.size() == 0)
            stop_with_failure("disp_credit pulsed before any entry had issued");
        credit_pulses++;
        disp_credits++;
    end
    if (alu_pipe[1])
        owed++;
    alu_pipe     = {alu_pipe[0], issue_valid === 1'b1};  // ~two cycles of ALU latency
    issue_credit = (owed > 0) && (!alu_hold || release_one);
    if (issue_credit) begin
        owed--;
        release_one = 1'b0;
    end
    disp_valid = 1'b0;
    wake_valid = '0;
    flush      = 1'b0;
endtask

task automatic idle(input int n);
    repeat (n) tick();
endtask

task automatic wait_issues(input int n, input int limit);
    int cycles;
    cycles = 0;
    while (issued_q.size() < n) begin
        if (cycles == limit)
            stop_with_failure($sformatf("timed out waiting for issue number %0d", n));
        tick();
        cycles++;
    end
endtask

// all dispatch and ALU credits back home
task automatic settle(input int limit);
    int cycles;
    cycles = 0;
    while (disp_credits != DEPTH || owed != 0 || alu_pipe != '0) begin
        if (cycles == limit)
            stop_with_failure("station did not drain, credits still outstanding");
        tick();
        cycles++;
    end
endtask

task automatic begin_test(input string name);
    settle(100);
    issued_q.delete();
    expect_q.delete();
    credit_pulses = 0;
    $display("test: %s", name);
endtask

task automatic compare_issued();
    check_count("issue count", expect_q.size(), issued_q.size());
    foreach (expect_q[i]) begin
        check_inst_num("issue_inst_num", expect_q[i].inst_num, issued_q[i].inst_num);
        check_tag("issue_rd", expect_q[i].rd, issued_q[i].rd);
        check_tag("issue_src1_tag", expect_q[i].src1_tag, issued_q[i].src1_tag);
        check_tag("issue_src2_tag", expect_q[i].src2_tag, issued_q[i].src2_tag);
        check_imm("issue_imm", expect_q[i].imm, issued_q[i].imm);
        check_ctrl("issue_alu_op", expect_q[i].alu_op, issued_q[i].alu_op);
        check_ctrl("issue_funct3", alu_op_t'(expect_q[i].funct3), alu_op_t'(issued_q[i].funct3));
        check_ctrl("issue_mem_to_reg", alu_op_t'(expect_q[i].mem_to_reg),
                   alu_op_t'(issued_q[i].mem_to_reg));
        check_ctrl("issue_mem_read", alu_op_t'(expect_q[i].mem_read),
                   alu_op_t'(issued_q[i].mem_read));
        check_ctrl("issue_mem_write", alu_op_t'(expect_q[i].mem_write),
                   alu_op_t'(issued_q[i].mem_write));
        check_ctrl("issue_alu_src2", alu_op_t'(expect_q[i].alu_src2),
                   alu_op_t'(issued_q[i].alu_src2));
    end
endtask

task automatic dispatch_ready(input int n);
    repeat (n) begin
        expect_q.push_back(make_entry(1'b0, '0));
        drive_dispatch(expect_q[$]);
        tick();
    end
endtask

task automatic test_in_order_issue();
    begin_test("in-order issue");
    dispatch_ready(5);
    wait_issues(5, 60);
    compare_issued();
endtask

task automatic test_wakeup_order();
    entry_t old_e;
    entry_t young_e;
    begin_test("wakeup and out-of-order issue");
    old_e   = make_entry(1'b1, 8'ha5);
    young_e = make_entry(1'b0, '0);
    drive_dispatch(old_e);
    tick();
    drive_dispatch(young_e);
    tick();
    expect_q.push_back(young_e);
    wait_issues(1, 20);
    drive_wake(0, 8'h5a);  // no entry waits on this one
    tick();
    idle(8);
    compare_issued();
    drive_wake(2, 8'ha5);
    tick();
    expect_q.push_back(old_e);
    wait_issues(2, 20);
    compare_issued();
endtask

task automatic test_dispatch_bypass();
    entry_t e;
    begin_test("dispatch bypass");
    e = make_entry(1'b1, 8'h3c);
    drive_dispatch(e);
    drive_wake(1, 8'h3c);  // same cycle as the dispatch
    tick();
    expect_q.push_back(e);
    wait_issues(1, 20);
    compare_issued();
endtask

task automatic test_issue_backpressure();
    begin_test("issue back-pressure");
    alu_hold = 1'b1;
    dispatch_ready(4);
    idle(10);
    check_count("issues with ALU credit held", ISSUE_CREDITS, issued_q.size());
    release_one = 1'b1;
    idle(10);
    check_count("issues after one credit", ISSUE_CREDITS + 1, issued_q.size());
    alu_hold = 1'b0;
    wait_issues(4, 30);
    compare_issued();
endtask

task automatic test_dispatch_credits();
    begin_test("dispatch credit accounting");
    no_early_credit = 1'b1;
    repeat (DEPTH) begin
        expect_q.push_back(make_entry(1'b1, 8'h77));  // fill the station with waiting work
        drive_dispatch(expect_q[$]);
        tick();
    end
    idle(4);
    check_count("issues while full", 0, issued_q.size());
    drive_wake(0, 8'h77);
    tick();
    wait_issues(DEPTH, 100);
    compare_issued();
    settle(100);
    idle(4);
    check_count("disp_credit pulses", DEPTH, credit_pulses);
    no_early_credit = 1'b0;
endtask

task automatic test_flush();
    tag_t wait_tag;
    begin_test("flush");
    wait_tag = 8'hc0;
    repeat (3) begin
        drive_dispatch(make_entry(1'b1, wait_tag));
        tick();
        wait_tag++;
    end
    idle(3);
    check_count("issues before flush", 0, issued_q.size());
    drive_dispatch(make_entry(1'b0, '0));  // dropped together with the flush
    flush = 1'b1;
    tick();
    disp_credits = DEPTH;
    drive_wake(0, 8'hc0);
    drive_wake(1, 8'hc1);
    drive_wake(2, 8'hc2);
    tick();
    idle(10);
    check_count("issues after flush", 0, issued_q.size());
    check_count("disp_credit pulses after flush", 0, credit_pulses);
    dispatch_ready(3);
    wait_issues(3, 30);
    compare_issued();
endtask

`endif

// File: bench/rs_tb.sv
`timescale 1ns/1ps

module rs_tb
    import rs_pkg::*;
();
    localparam int DEPTH         = 8;
    localparam int WINDOW        = 4;
    localparam int N_WAKE        = 3;
    localparam int ISSUE_CREDITS = 2;
    localparam int CLK_PERIOD    = 100;
    localparam int N_TESTS       = 6;

    // one dispatched or issued instruction
    typedef struct {
        inst_num_t inst_num;
        tag_t      rd;
        logic      mem_to_reg;
        logic      mem_read;
        logic      mem_write;
        alu_op_t   alu_op;
        logic      alu_src2;
        funct3_t   funct3;
        imm_t      imm;
        tag_t      src1_tag;
        tag_t      src2_tag;
        logic      src1_ready;
        logic      src2_ready;
    } entry_t;

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic              disp_valid;
    entry_t            disp;          // dispatch payload, fans out to the disp_* ports
    logic [N_WAKE-1:0] wake_valid;
    tag_t [N_WAKE-1:0] wake_tag;
    logic              issue_credit;
    logic              disp_credit;
    logic              issue_valid;
    inst_num_t         issue_inst_num;
    tag_t              issue_rd;
    logic              issue_mem_to_reg;
    logic              issue_mem_read;
    logic              issue_mem_write;
    alu_op_t           issue_alu_op;
    logic              issue_alu_src2;
    funct3_t           issue_funct3;
    imm_t              issue_imm;
    tag_t              issue_src1_tag;
    tag_t              issue_src2_tag;

    entry_t      expect_q[$];
    entry_t      issued_q[$];
    logic [31:0] rng_state       = 32'hd8d1;
    int          disp_credits    = DEPTH;  // dispatcher side credit count
    int          credit_pulses   = 0;
    int          owed            = 0;      // ALU credits waiting to go back
    logic [1:0]  alu_pipe        = '0;
    logic        alu_hold        = 1'b0;
    logic        release_one     = 1'b0;
    logic        no_early_credit = 1'b0;

    rs_top #(
        .DEPTH         (DEPTH),
        .WINDOW        (WINDOW),
        .N_WAKE        (N_WAKE),
        .ISSUE_CREDITS (ISSUE_CREDITS)
    ) UUT (
        .disp_inst_num   (disp.inst_num),
        .disp_rd         (disp.rd),
        .disp_mem_to_reg (disp.mem_to_reg),
        .disp_mem_read   (disp.mem_read),
        .disp_mem_write  (disp.mem_write),
        .disp_alu_op     (disp.alu_op),
        .disp_alu_src2   (disp.alu_src2),
        .disp_funct3     (disp.funct3),
        .disp_imm        (disp.imm),
        .disp_src1_tag   (disp.src1_tag),
        .disp_src2_tag   (disp.src2_tag),
        .disp_src1_ready (disp.src1_ready),
        .disp_src2_ready (disp.src2_ready),
        .*
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

`include "rs_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 200 cycles per test plus reset and some slack
    initial begin
        #((N_TESTS * 200 + 50) * CLK_PERIOD);
        stop_with_failure("watchdog expired, the test sequence did not finish in time");
    end

    initial begin
        rst_n        = 1'b0;
        flush        = 1'b0;
        disp_valid   = 1'b0;
        disp         = '{default: '0};
        wake_valid   = '0;
        wake_tag     = '0;
        issue_credit = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        test_in_order_issue();
        test_wakeup_order();
        test_dispatch_bypass();
        test_issue_backpressure();
        test_dispatch_credits();
        test_flush();
        settle(100);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
rtl/rs_pkg.sv
rtl/rs_entry_if.sv
rtl/rs_entry_store.sv
rtl/rs_wakeup.sv
rtl/rs_select.sv
rtl/rs_top.sv
bench/rs_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module rs_tb -f filelist.f -o rs_sim
	@out="$$(./obj_dir/rs_sim 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
